// ==== design/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int RAM_WORDS   = 1024,
    parameter int VIDEO_WORDS = 512,
    parameter int SCAN_DIV    = 4  // short for simulation
) (
    input  logic                           clk_in,
    input  logic                           arst_n,
    input  logic                           req_valid,
    input  soc_pkg::bus_req_t              req,
    input  logic [31:0]                    pc,
    input  logic [$clog2(VIDEO_WORDS)-1:0] scan_addr,
    output logic                           resp_valid,
    output soc_pkg::bus_resp_t             resp,
    output logic [31:0]                    instr,
    output logic [31:0]                    scan_data,
    output logic [15:0]                    led,
    output logic [7:0]                     an,
    output logic [6:0]                     cat
);

    soc_pkg::bus_req_t tgt_req;  // word addressed, shared by all targets
    logic              ram_sel, video_sel, periph_sel;
    logic [31:0]       ram_rdata, video_rdata, periph_rdata;
    logic [31:0]       debug_value;

    ////////////////////////////////////////
    // bus decode

    memory_controller memory_ctrl (
        .clk_in(clk_in), .arst_n(arst_n),
        .req_valid(req_valid), .req(req),
        .ram_rdata(ram_rdata), .video_rdata(video_rdata), .periph_rdata(periph_rdata),
        .tgt_req(tgt_req),
        .ram_sel(ram_sel), .video_sel(video_sel), .periph_sel(periph_sel),
        .resp_valid(resp_valid), .resp(resp)
    );

    ////////////////////////////////////////
    // targets

    program_ram #(.RAM_WORDS(RAM_WORDS)) data_memory (
        .clk_in(clk_in), .sel(ram_sel), .tgt_req(tgt_req),
        .pc(pc), .rdata(ram_rdata), .instr(instr)
    );

    video_buffer #(.VIDEO_WORDS(VIDEO_WORDS)) frame_buffer (
        .clk_in(clk_in), .sel(video_sel), .tgt_req(tgt_req),
        .scan_addr(scan_addr), .rdata(video_rdata), .scan_data(scan_data)
    );

    periph_regs regs (
        .clk_in(clk_in), .arst_n(arst_n), .sel(periph_sel), .tgt_req(tgt_req),
        .rdata(periph_rdata), .debug_value(debug_value), .led(led)
    );

    seven_segment_controller #(.SCAN_DIV(SCAN_DIV)) mssc (
        .clk_in(clk_in), .arst_n(arst_n),
        .val(debug_value), .an(an), .cat(cat)
    );

endmodule

// ==== design/memory_controller.sv ====
`timescale 1ns/1ps

module memory_controller (
    input  logic              clk_in,
    input  logic              arst_n,
    input  logic              req_valid,
    input  soc_pkg::bus_req_t req,
    input  logic [31:0]       ram_rdata,
    input  logic [31:0]       video_rdata,
    input  logic [31:0]       periph_rdata,
    output soc_pkg::bus_req_t tgt_req,
    output logic              ram_sel,
    output logic              video_sel,
    output logic              periph_sel,
    output logic              resp_valid,
    output soc_pkg::bus_resp_t resp
);

    soc_pkg::region_e region;     // decode of the current request
    soc_pkg::region_e rd_region;  // region of the read in flight
    logic             is_read;

    assign region  = soc_pkg::region_e'(req.addr[29:28]);
    assign is_read = (req.wstrb == 4'b0000);

    ////////////////////////////////////////
    // request side

    // targets see a word offset inside their region
    always_comb begin
        tgt_req      = req;
        tgt_req.addr = {6'd0, req.addr[27:2]};
    end

    // unmapped region gets no select, so writes there vanish
    assign ram_sel    = req_valid && (region == soc_pkg::REGION_RAM);
    assign video_sel  = req_valid && (region == soc_pkg::REGION_VIDEO);
    assign periph_sel = req_valid && (region == soc_pkg::REGION_PERIPH);

    ////////////////////////////////////////
    // response side

    // targets read synchronously, so the answer lines up one cycle later
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
            rd_region  <= soc_pkg::REGION_NONE;
        end else begin
            resp_valid <= req_valid && is_read;  // writes never answer
            rd_region  <= region;
        end
    end

    // steer the word from whichever target was hit
    always_comb begin
        case (rd_region)
            soc_pkg::REGION_RAM:    resp.rdata = ram_rdata;
            soc_pkg::REGION_VIDEO:  resp.rdata = video_rdata;
            soc_pkg::REGION_PERIPH: resp.rdata = periph_rdata;
            default:                resp.rdata = 32'd0;  // unmapped reads answer zero
        endcase
    end

endmodule

// ==== design/periph_regs.sv ====
`timescale 1ns/1ps

module periph_regs (
    input  logic              clk_in,
    input  logic              arst_n,
    input  logic              sel,
    input  soc_pkg::bus_req_t tgt_req,
    output logic [31:0]       rdata,
    output logic [31:0]       debug_value,
    output logic [15:0]       led
);

    logic hit_debug;
    logic hit_led;

    assign hit_debug = (tgt_req.addr == soc_pkg::REG_DEBUG_OFFSET);
    assign hit_led   = (tgt_req.addr == soc_pkg::REG_LED_OFFSET);

    // byte strobed register writes
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            debug_value <= 32'd0;
            led         <= 16'd0;
        end else if (sel) begin
            for (int b = 0; b < 4; b++) begin
                if (tgt_req.wstrb[b] && hit_debug) begin
                    debug_value[8*b +: 8] <= tgt_req.wdata[8*b +: 8];
                end
            end
            for (int b = 0; b < 2; b++) begin  // led keeps the low half only
                if (tgt_req.wstrb[b] && hit_led) begin
                    led[8*b +: 8] <= tgt_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // readback, zero for any other offset
    always_ff @(posedge clk_in) begin
        if (sel) begin
            rdata <= hit_debug ? debug_value :
                     hit_led   ? {16'd0, led} : 32'd0;
        end
    end

endmodule

// ==== design/program_ram.sv ====
`timescale 1ns/1ps

module program_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic              clk_in,
    input  logic              sel,
    input  soc_pkg::bus_req_t tgt_req,
    input  logic [31:0]       pc,
    output logic [31:0]       rdata,
    output logic [31:0]       instr
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] data_idx;
    logic [AW-1:0] fetch_idx;

    // both ports wrap at the array size
    assign data_idx  = AW'(tgt_req.addr % RAM_WORDS);
    assign fetch_idx = AW'((pc >> 2) % RAM_WORDS);  // pc is a byte address

    ////////////////////////////////////////
    // data port

    // read returns the old word when the same cycle writes it
    always_ff @(posedge clk_in) begin
        if (sel) begin
            for (int b = 0; b < 4; b++) begin
                if (tgt_req.wstrb[b]) begin
                    mem[data_idx][8*b +: 8] <= tgt_req.wdata[8*b +: 8];
                end
            end
            rdata <= mem[data_idx];
        end
    end

    ////////////////////////////////////////
    // fetch port

    always_ff @(posedge clk_in) begin
        instr <= mem[fetch_idx];  // valid one cycle after pc
    end

endmodule

// ==== design/seven_segment_controller.sv ====
`timescale 1ns/1ps

module seven_segment_controller #(
    parameter int SCAN_DIV = 4
) (
    input  logic        clk_in,
    input  logic        arst_n,
    input  logic [31:0] val,
    output logic [7:0]  an,
    output logic [6:0]  cat
);

    localparam int CW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CW-1:0] div_cnt;  // cycles spent on the current digit
    logic [2:0]    digit;
    logic          started;  // low until the first divider step
    logic [3:0]    nibble;

    ////////////////////////////////////////
    // digit scan

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            digit   <= 3'd0;
            started <= 1'b0;
        end else if (div_cnt == CW'(SCAN_DIV - 1)) begin
            div_cnt <= '0;
            started <= 1'b1;
            if (started) begin
                digit <= digit + 3'd1;  // wraps after 7
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // drive

    assign nibble = val[4*digit +: 4];

    // common anode, one low anode for the lit digit
    assign an  = started ? ~(8'b1 << digit) : 8'hff;
    assign cat = started ? soc_pkg::SEG_PATTERNS[nibble] : 7'h7f;

endmodule

// ==== design/soc_pkg.sv ====
package soc_pkg;

    ////////////////////////////////////////
    // data bus

    // cpu side request, one per valid cycle
    typedef struct packed {
        logic [31:0] addr;   // byte address, word offset once past the controller
        logic [31:0] wdata;
        logic [3:0]  wstrb;  // all zero means read
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } bus_resp_t;

    ////////////////////////////////////////
    // address map

    // taken from addr[29:28]
    typedef enum logic [1:0] {
        REGION_RAM    = 2'd0,
        REGION_VIDEO  = 2'd1,
        REGION_PERIPH = 2'd2,
        REGION_NONE   = 2'd3
    } region_e;

    // word offsets inside the peripheral region
    localparam int REG_DEBUG_OFFSET = 0;
    localparam int REG_LED_OFFSET   = 1;

    ////////////////////////////////////////
    // seven segment

    // cathodes {g,f,e,d,c,b,a}, low lights the segment
    localparam logic [6:0] SEG_PATTERNS [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30,  // 0 1 2 3
        7'h19, 7'h12, 7'h02, 7'h78,  // 4 5 6 7
        7'h00, 7'h10, 7'h08, 7'h03,  // 8 9 A b
        7'h46, 7'h21, 7'h06, 7'h0e   // C d E F
    };

endpackage

// ==== design/video_buffer.sv ====
`timescale 1ns/1ps

module video_buffer #(
    parameter int VIDEO_WORDS = 512
) (
    input  logic                           clk_in,
    input  logic                           sel,
    input  soc_pkg::bus_req_t              tgt_req,
    input  logic [$clog2(VIDEO_WORDS)-1:0] scan_addr,
    output logic [31:0]                    rdata,
    output logic [31:0]                    scan_data
);

    localparam int AW = $clog2(VIDEO_WORDS);

    logic [31:0]   frame [VIDEO_WORDS];
    logic [AW-1:0] cpu_idx;

    assign cpu_idx = AW'(tgt_req.addr % VIDEO_WORDS);

    ////////////////////////////////////////
    // cpu port

    // same lane rule as the program ram
    always_ff @(posedge clk_in) begin
        if (sel) begin
            for (int b = 0; b < 4; b++) begin
                if (tgt_req.wstrb[b]) begin
                    frame[cpu_idx][8*b +: 8] <= tgt_req.wdata[8*b +: 8];
                end
            end
            rdata <= frame[cpu_idx];
        end
    end

    ////////////////////////////////////////
    // scan port

    // read only, free running beside cpu traffic
    always_ff @(posedge clk_in) begin
        scan_data <= frame[scan_addr];
    end

endmodule

// ==== mem_subsystem.f ====
design/soc_pkg.sv
design/memory_controller.sv
design/program_ram.sv
design/video_buffer.sv
design/periph_regs.sv
design/seven_segment_controller.sv
design/mem_subsystem.sv
test/tb_mem_subsystem.sv

// ==== test/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int RAM_WORDS   = 1024;
    localparam int VIDEO_WORDS = 512;
    localparam int SCAN_DIV    = 4;
    localparam int VW          = $clog2(VIDEO_WORDS);

    logic               clk_in = 1'b0;
    logic               arst_n;
    logic               req_valid;
    soc_pkg::bus_req_t  req;
    logic [31:0]        pc;
    logic [VW-1:0]      scan_addr;
    logic               resp_valid;
    soc_pkg::bus_resp_t resp;
    logic [31:0]        instr, scan_data;
    logic [15:0]        led;
    logic [7:0]         an;
    logic [6:0]         cat;

    logic [31:0] ram_shadow [RAM_WORDS];
    logic [31:0] video_shadow [VIDEO_WORDS];
    logic [31:0] debug_shadow = 32'd0;
    logic [15:0] led_shadow = 16'd0;
    logic [31:0] exp_q [$];  // expected rdata per pending read
    int          due_q [$];  // cycle each response must arrive in
    int          ram_idx [16];
    int          vid_idx [16];
    logic [31:0] lcg_state = 32'd56;
    int          cyc = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          passed = 0;
    int          failed = 0;

    mem_subsystem #(.RAM_WORDS(RAM_WORDS), .VIDEO_WORDS(VIDEO_WORDS), .SCAN_DIV(SCAN_DIV)) DUT (
        .clk_in(clk_in), .arst_n(arst_n), .req_valid(req_valid), .req(req), .pc(pc),
        .scan_addr(scan_addr), .resp_valid(resp_valid), .resp(resp), .instr(instr),
        .scan_data(scan_data), .led(led), .an(an), .cat(cat)
    );

    always #20 clk_in = ~clk_in;

    always @(posedge clk_in) cyc <= cyc + 1;

    ////////////////////////////////////////
    // reference model

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] ref_rdata(input logic [31:0] addr);
        logic [25:0] w;
        w = addr[27:2];
        case (soc_pkg::region_e'(addr[29:28]))
            soc_pkg::REGION_RAM:    return ram_shadow[w % RAM_WORDS];
            soc_pkg::REGION_VIDEO:  return video_shadow[w % VIDEO_WORDS];
            soc_pkg::REGION_PERIPH: begin
                if (w == soc_pkg::REG_DEBUG_OFFSET) return debug_shadow;
                if (w == soc_pkg::REG_LED_OFFSET) return {16'd0, led_shadow};
                return 32'd0;  // unused offsets
            end
            default:                return 32'd0;
        endcase
    endfunction

    // expected {an, cat} for a lit digit
    function automatic logic [14:0] seg_ref(input int idx, input logic [31:0] value);
        return {~(8'b1 << idx), soc_pkg::SEG_PATTERNS[value[4*idx +: 4]]};
    endfunction

    task automatic apply_write(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] strb);
        logic [25:0] w;
        logic [31:0] tmp;
        w = addr[27:2];
        case (soc_pkg::region_e'(addr[29:28]))
            soc_pkg::REGION_RAM:   ram_shadow[w % RAM_WORDS] =
                                       merge_bytes(ram_shadow[w % RAM_WORDS], wdata, strb);
            soc_pkg::REGION_VIDEO: video_shadow[w % VIDEO_WORDS] =
                                       merge_bytes(video_shadow[w % VIDEO_WORDS], wdata, strb);
            soc_pkg::REGION_PERIPH: begin
                if (w == soc_pkg::REG_DEBUG_OFFSET) begin
                    debug_shadow = merge_bytes(debug_shadow, wdata, strb);
                end
                if (w == soc_pkg::REG_LED_OFFSET) begin
                    tmp = merge_bytes({16'd0, led_shadow}, wdata, strb);
                    led_shadow = tmp[15:0];
                end
            end
            default: ;  // unmapped writes vanish
        endcase
    endtask

    function automatic logic [31:0] ram_addr(input int idx);
        return 32'(idx) << 2;
    endfunction

    function automatic logic [31:0] video_addr(input int idx);
        return 32'h1000_0000 | (32'(idx) << 2);
    endfunction

    function automatic logic [31:0] periph_addr(input int off);
        return 32'h2000_0000 | (32'(off) << 2);
    endfunction

    ////////////////////////////////////////
    // bus driving and checking

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb);
        @(negedge clk_in);
        req_valid = 1'b1;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = strb;
        if (strb == 4'b0000) begin
            exp_q.push_back(ref_rdata(addr));
            due_q.push_back(cyc + 1);
        end else begin
            apply_write(addr, wdata, strb);
        end
    endtask

    task automatic bus_idle();
        @(negedge clk_in);
        req_valid = 1'b0;
        req       = '0;
    endtask

    task automatic drain_responses();
        int waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk_in);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d read responses never arrived", exp_q.size());
            $display("tests failed");
            $finish;
        end
    endtask

    task automatic end_test(input string name);
        drain_responses();
        if (errors == test_errors) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: FAIL with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // outputs sampled at the rising edge before the registers move
    always @(posedge clk_in) begin
        if (resp_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR t=%0t read response arrived with no read pending", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                assert (due_q[0] == cyc) else begin
                    $display("ERROR t=%0t read response came in cycle %0d, expected %0d",
                             $time, cyc, due_q[0]);
                    errors++;
                end
                assert (resp.rdata === exp_q[0]) else
                    report_mismatch("resp.rdata", resp.rdata, exp_q[0]);
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end else if (exp_q.size() != 0) begin
            assert (due_q[0] > cyc) else begin
                $display("ERROR t=%0t read response missing in cycle %0d", $time, cyc);
                errors++;
            end
            if (due_q[0] <= cyc) begin
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////
    // test sequence

    initial begin
        logic [31:0] r;
        logic [7:0]  seen;
        int          digit;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        pc        = 32'd0;
        scan_addr = '0;
        repeat (8) @(negedge clk_in);
        arst_n = 1'b1;
        assert (resp_valid === 1'b0) else report_mismatch("resp_valid", 32'(resp_valid), 32'd0);
        assert (led === 16'd0) else report_mismatch("led", 32'(led), 32'd0);
        assert (an === 8'hff) else report_mismatch("an", 32'(an), 32'hff);
        end_test("reset state");

        // full ram words first so partial writes merge into known data
        for (int i = 0; i < 16; i++) begin
            ram_idx[i] = int'((lcg_next() >> 8) % RAM_WORDS);
            bus_access(ram_addr(ram_idx[i]), lcg_next(), 4'hf);
        end
        for (int i = 0; i < 32; i++) begin
            r = lcg_next();
            bus_access(ram_addr(ram_idx[r[27:24]]), lcg_next(), r[11:8]);  // zero strobe reads
        end
        for (int i = 0; i < 16; i++) bus_access(ram_addr(ram_idx[i]), 32'd0, 4'h0);
        bus_idle();
        end_test("ram byte writes");

        for (int i = 0; i < 4; i++) bus_access(ram_addr(ram_idx[i]), lcg_next(), 4'hf);
        bus_idle();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk_in);
            pc = ram_addr(ram_idx[i]);
            @(negedge clk_in);
            assert (instr === ram_shadow[ram_idx[i]]) else
                report_mismatch("instr", instr, ram_shadow[ram_idx[i]]);
        end
        end_test("instruction fetch");

        for (int i = 0; i < 16; i++) begin
            vid_idx[i] = int'((lcg_next() >> 8) % VIDEO_WORDS);
            bus_access(video_addr(vid_idx[i]), lcg_next(), 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            bus_access(video_addr(vid_idx[r[27:24]]), lcg_next(), r[11:8]);
        end
        // scan port checked beside back to back cpu reads
        for (int i = 0; i <= 16; i++) begin
            bus_access(video_addr(vid_idx[(i + 3) % 16]), 32'd0, 4'h0);
            if (i > 0) begin
                assert (scan_data === video_shadow[vid_idx[i-1]]) else
                    report_mismatch("scan_data", scan_data, video_shadow[vid_idx[i-1]]);
            end
            if (i < 16) scan_addr = VW'(vid_idx[i]);
        end
        bus_idle();
        end_test("video buffer");

        bus_access(periph_addr(soc_pkg::REG_DEBUG_OFFSET), lcg_next(), 4'hf);
        bus_access(periph_addr(soc_pkg::REG_DEBUG_OFFSET), lcg_next(), 4'b0101);
        bus_access(periph_addr(soc_pkg::REG_LED_OFFSET), lcg_next(), 4'hf);
        bus_access(periph_addr(soc_pkg::REG_LED_OFFSET), lcg_next(), 4'b0010);
        for (int off = 0; off < 6; off++) bus_access(periph_addr(off), 32'd0, 4'h0);
        bus_idle();
        assert (led === led_shadow) else report_mismatch("led", 32'(led), 32'(led_shadow));
        end_test("peripheral registers");

        bus_access(periph_addr(soc_pkg::REG_DEBUG_OFFSET), lcg_next(), 4'hf);
        bus_idle();
        bus_idle();
        seen = 8'h00;
        for (int n = 0; n < 8 * SCAN_DIV; n++) begin
            @(negedge clk_in);
            assert ($countones(~an) == 1) else begin
                $display("ERROR t=%0t anodes %b do not light exactly one digit", $time, an);
                errors++;
            end
            digit = 0;
            for (int d = 0; d < 8; d++) begin
                if (!an[d]) digit = d;  // index from the observed anode
            end
            seen[digit] = 1'b1;
            assert ({an, cat} === seg_ref(digit, debug_shadow)) else
                report_mismatch("an,cat", 32'({an, cat}), 32'(seg_ref(digit, debug_shadow)));
        end
        assert (seen == 8'hff) else begin
            $display("ERROR only digits %b were lit during one full scan", seen);
            errors++;
        end
        end_test("seven segment");

        for (int i = 0; i < 8; i++) begin
            bus_access(32'h3000_0000 | ram_addr(ram_idx[i]), lcg_next(), 4'hf);
            bus_access(32'h3000_0000 | ram_addr(vid_idx[i]), lcg_next(), 4'hf);
        end
        for (int i = 0; i < 4; i++) bus_access(32'h3000_0000 | ram_addr(ram_idx[i]), 32'd0, 4'h0);
        for (int i = 0; i < 16; i++) begin
            bus_access(ram_addr(ram_idx[i]), 32'd0, 4'h0);
            bus_access(video_addr(vid_idx[i]), 32'd0, 4'h0);
        end
        bus_access(periph_addr(soc_pkg::REG_DEBUG_OFFSET), 32'd0, 4'h0);
        bus_access(periph_addr(soc_pkg::REG_LED_OFFSET), 32'd0, 4'h0);
        bus_idle();
        end_test("unmapped region");

        $display("summary: %0d passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
